/* sources.f */
hw/dma_pkg.sv
hw/dma_regs.sv
hw/dma_engine.sv
hw/bus_arbiter.sv
hw/word_ram.sv
hw/dma_system.sv
bench/tb_clock_gen.sv
bench/dma_assert.sv
bench/tb_dma_system.sv

/* bench/tb_dma_system.sv */
`timescale 1ns/1ps

module tb_dma_system import dma_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000; // Summed test length plus margin
	localparam logic [ADDR_WIDTH-1:0] BASIC_SRC = 32'h0000_0000;
	localparam logic [ADDR_WIDTH-1:0] BASIC_DST = 32'h0000_0080;
	localparam logic [ADDR_WIDTH-1:0] ZERO_DST = 32'h0000_00e0;
	localparam logic [ADDR_WIDTH-1:0] CONT_SRC = 32'h0000_0100;
	localparam logic [ADDR_WIDTH-1:0] CONT_DST = 32'h0000_0200;
	localparam logic [ADDR_WIDTH-1:0] HOST_REGION = 32'h0000_0300;
	localparam logic [ADDR_WIDTH-1:0] SRC_A = 32'h0000_0180;
	localparam logic [ADDR_WIDTH-1:0] DST_A = 32'h0000_01a0;
	localparam logic [ADDR_WIDTH-1:0] SRC_B = 32'h0000_01c0;
	localparam logic [ADDR_WIDTH-1:0] DST_B = 32'h0000_01e0;

	logic i_clock;
	logic i_arst_n;
	logic reg_request;
	logic reg_rw;
	reg_addr_t reg_address;
	logic [DATA_WIDTH-1:0] reg_wdata;
	logic [DATA_WIDTH-1:0] reg_rdata;
	logic reg_ready;
	logic host_request;
	logic host_rw;
	logic [ADDR_WIDTH-1:0] host_address;
	logic [DATA_WIDTH-1:0] host_wdata;
	logic [DATA_WIDTH-1:0] host_rdata;
	logic host_ready;
	logic busy;
	logic done;
	logic busy_seen;
	logic [DATA_WIDTH-1:0] model [RAM_WORDS]; // Expected RAM contents
	integer seed;
	int cycle_count = 0;

	tb_clock_gen u_clock_gen (
		.o_clock(i_clock),
		.o_arst_n(i_arst_n)
	);

	dma_system i_dma_system (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_reg_request(reg_request),
		.i_reg_rw(reg_rw),
		.i_reg_address(reg_address),
		.i_reg_wdata(reg_wdata),
		.o_reg_rdata(reg_rdata),
		.o_reg_ready(reg_ready),
		.i_host_request(host_request),
		.i_host_rw(host_rw),
		.i_host_address(host_address),
		.i_host_wdata(host_wdata),
		.o_host_rdata(host_rdata),
		.o_host_ready(host_ready),
		.o_busy(busy),
		.o_done(done)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic compare_data(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	task automatic compare_reg(input reg_addr_t address, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: o_reg_rdata(%s) expected %h actual %h",
				$time, address.name(), expected, actual));
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: %s expected %b actual %b",
				$time, name, expected, actual));
	endtask

	function automatic int word_index(input logic [ADDR_WIDTH-1:0] address);
		return int'((address / WORD_BYTES) % RAM_WORDS);
	endfunction

	// Every byte of the word depends on the full index
	function automatic logic [DATA_WIDTH-1:0] fill_word(input int index);
		return {8'(index) ^ 8'h5a, ~8'(index), 8'(index * 3), 8'(index)};
	endfunction

	task automatic reg_write(input reg_addr_t address, input logic [DATA_WIDTH-1:0] value);
		reg_request = 1'b1;
		reg_rw = 1'b1;
		reg_address = address;
		reg_wdata = value;
		@(posedge i_clock);
		#1;
		reg_request = 1'b0;
		compare_flag("o_reg_ready", 1'b1, reg_ready);
	endtask

	task automatic reg_read(input reg_addr_t address, input logic [DATA_WIDTH-1:0] expected);
		reg_request = 1'b1;
		reg_rw = 1'b0;
		reg_address = address;
		@(posedge i_clock);
		#1;
		reg_request = 1'b0;
		compare_flag("o_reg_ready", 1'b1, reg_ready);
		compare_reg(address, expected, reg_rdata);
	endtask

	// Holds the request until ready, then leaves one idle cycle
	task automatic host_access(input logic rw, input logic [ADDR_WIDTH-1:0] address,
		input logic [DATA_WIDTH-1:0] wdata, output logic [DATA_WIDTH-1:0] rdata);
		host_request = 1'b1;
		host_rw = rw;
		host_address = address;
		host_wdata = wdata;
		do begin
			@(posedge i_clock);
			#1;
		end while (!host_ready);
		rdata = host_rdata;
		host_request = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	task automatic host_write(input logic [ADDR_WIDTH-1:0] address,
		input logic [DATA_WIDTH-1:0] value);
		logic [DATA_WIDTH-1:0] unused;
		host_access(1'b1, address, value, unused);
		model[word_index(address)] = value;
	endtask

	task automatic host_read(input logic [ADDR_WIDTH-1:0] address);
		logic [DATA_WIDTH-1:0] value;
		host_access(1'b0, address, '0, value);
		compare_data($sformatf("o_host_rdata[%h]", address), model[word_index(address)], value);
	endtask

	task automatic start_copy(input logic [ADDR_WIDTH-1:0] src, input logic [ADDR_WIDTH-1:0] dst,
		input int count);
		reg_write(reg_from, src);
		reg_write(reg_to, dst);
		reg_write(reg_count, DATA_WIDTH'(count));
		reg_write(reg_ctrl, '0);
	endtask

	task automatic wait_done();
		busy_seen = 1'b0;
		while (!done) begin
			@(posedge i_clock);
			#1;
			busy_seen = busy_seen | busy;
		end
		compare_flag("o_busy during copy", 1'b1, busy_seen);
		compare_flag("o_busy", 1'b0, busy);
	endtask

	task automatic model_copy(input logic [ADDR_WIDTH-1:0] src, input logic [ADDR_WIDTH-1:0] dst,
		input int count);
		for (int i = 0; i < count; i++)
			model[word_index(dst + i * WORD_BYTES)] = model[word_index(src + i * WORD_BYTES)];
	endtask

	task automatic verify_words(input logic [ADDR_WIDTH-1:0] address, input int count);
		for (int i = 0; i < count; i++)
			host_read(address + i * WORD_BYTES);
	endtask

	task automatic preload_random(input logic [ADDR_WIDTH-1:0] address, input int count);
		for (int i = 0; i < count; i++)
			host_write(address + i * WORD_BYTES, $random(seed));
	endtask

	task automatic host_traffic(input int ops);
		logic [31:0] pick;
		for (int i = 0; i < ops; i++) begin
			pick = $random(seed);
			if (pick[5])
				host_write(HOST_REGION + WORD_BYTES * pick[4:0], $random(seed));
			else
				host_read(HOST_REGION + WORD_BYTES * pick[4:0]);
		end
	endtask

	task automatic test_reset();
		logic [DATA_WIDTH-1:0] from_value;
		logic [DATA_WIDTH-1:0] to_value;
		logic [DATA_WIDTH-1:0] count_value;
		compare_flag("o_busy", 1'b0, busy);
		compare_flag("o_done", 1'b0, done);
		reg_read(reg_from, '0);
		reg_read(reg_to, '0);
		reg_read(reg_count, '0);
		reg_read(reg_ctrl, '0);
		from_value = $random(seed);
		to_value = $random(seed);
		count_value = $random(seed);
		reg_write(reg_from, from_value);
		reg_write(reg_to, to_value);
		reg_write(reg_count, count_value);
		reg_read(reg_from, from_value);
		reg_read(reg_to, to_value);
		reg_read(reg_count, count_value);
	endtask

	task automatic test_basic_copy();
		preload_random(BASIC_SRC, 16);
		start_copy(BASIC_SRC, BASIC_DST, 16);
		wait_done();
		model_copy(BASIC_SRC, BASIC_DST, 16);
		verify_words(BASIC_DST, 17); // Last word lies past the copy
	endtask

	task automatic test_zero_count();
		start_copy(BASIC_SRC, ZERO_DST, 0);
		compare_flag("o_done", 1'b0, done);
		@(posedge i_clock);
		#1;
		compare_flag("o_done", 1'b1, done);
		compare_flag("o_busy", 1'b0, busy);
		@(posedge i_clock);
		#1;
		compare_flag("o_done", 1'b0, done);
		verify_words(ZERO_DST, 4);
		start_copy(BASIC_SRC, ZERO_DST, 1);
		wait_done();
		model_copy(BASIC_SRC, ZERO_DST, 1);
		verify_words(ZERO_DST, 4);
	endtask

	task automatic test_contention();
		preload_random(CONT_SRC, 32);
		start_copy(CONT_SRC, CONT_DST, 32);
		fork
			wait_done();
			host_traffic(40);
		join
		model_copy(CONT_SRC, CONT_DST, 32);
		verify_words(CONT_DST, 33);
	endtask

	task automatic test_start_while_busy();
		preload_random(SRC_A, 8);
		preload_random(SRC_B, 8);
		start_copy(SRC_A, DST_A, 8);
		start_copy(SRC_B, DST_B, 8); // Engine ignores this start
		reg_read(reg_ctrl, '1);
		reg_read(reg_from, SRC_B);
		wait_done();
		model_copy(SRC_A, DST_A, 8);
		verify_words(DST_A, 8);
		verify_words(DST_B, 8);
		reg_write(reg_ctrl, '0);
		wait_done();
		model_copy(SRC_B, DST_B, 8);
		verify_words(DST_B, 8);
	endtask

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("Timeout, tests still running after %0d cycles", cycle_count));
		else if (i_dma_system.u_assert.assert_errors != 0)
			stop_on_error("A concurrent assertion in dma_assert failed");
	end

	initial begin
		seed = 32'heb05_9b88;
		reg_request = 1'b0;
		reg_rw = 1'b0;
		reg_address = reg_from;
		reg_wdata = '0;
		host_request = 1'b0;
		host_rw = 1'b0;
		host_address = '0;
		host_wdata = '0;
		busy_seen = 1'b0;
		wait (i_arst_n === 1'b1);
		@(posedge i_clock);
		#1;
		test_reset();
		for (int i = 0; i < RAM_WORDS; i++)
			host_write(i * WORD_BYTES, fill_word(i));
		test_basic_copy();
		test_zero_count();
		test_contention();
		test_start_while_busy();
		if (i_dma_system.u_assert.assert_errors == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Concurrent assertions in dma_assert failed during the run");
			$display("SOME TESTS FAILED");
			$fatal(1, "run ended with assertion failures");
		end
	end

endmodule

/* bench/dma_assert.sv */
`timescale 1ns/1ps

module dma_assert import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_reg_request,
	input logic i_reg_ready,
	input logic i_host_request,
	input logic i_dma_request,
	input logic i_dma_ready,
	input bus_owner_t i_owner,
	input engine_state_t i_state,
	input logic i_busy,
	input logic i_done
);

	int assert_errors = 0;

	reg_ready_follows: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_reg_request |=> i_reg_ready)
		else begin
			$error("register request not acknowledged on the next cycle");
			assert_errors++;
		end

	// Arbiter stays free while nobody asks
	no_idle_grant: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_owner == own_none && !i_host_request && !i_dma_request) |=> (i_owner == own_none))
		else begin
			$error("arbiter granted the RAM with no request pending");
			assert_errors++;
		end

	dma_request_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_state != st_idle && i_dma_request && !i_dma_ready) |=> i_dma_request)
		else begin
			$error("engine dropped its bus request before ready");
			assert_errors++;
		end

	idle_after_done: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_done |=> !i_busy)
		else begin
			$error("engine still busy in the cycle after done");
			assert_errors++;
		end

endmodule

bind dma_system dma_assert u_assert (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_reg_request(i_reg_request),
	.i_reg_ready(o_reg_ready),
	.i_host_request(i_host_request),
	.i_dma_request(dma_request),
	.i_dma_ready(dma_ready),
	.i_owner(u_arbiter.owner),
	.i_state(u_engine.state),
	.i_busy(o_busy),
	.i_done(o_done)
);

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_arst_n
);

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;

	initial begin
		o_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) o_clock = ~o_clock;
	end

	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		@(negedge o_clock); // Release away from the rising edge
		o_arst_n = 1'b1;
	end

endmodule

/* hw/dma_system.sv */
`timescale 1ns/1ps

module dma_system import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_reg_request,
	input logic i_reg_rw,
	input reg_addr_t i_reg_address,
	input logic [DATA_WIDTH-1:0] i_reg_wdata,
	output logic [DATA_WIDTH-1:0] o_reg_rdata,
	output logic o_reg_ready,

	// Host memory port
	input logic i_host_request,
	input logic i_host_rw,
	input logic [ADDR_WIDTH-1:0] i_host_address,
	input logic [DATA_WIDTH-1:0] i_host_wdata,
	output logic [DATA_WIDTH-1:0] o_host_rdata,
	output logic o_host_ready,

	output logic o_busy,
	output logic o_done
);

	logic start;
	logic [ADDR_WIDTH-1:0] from;
	logic [ADDR_WIDTH-1:0] to;
	logic [DATA_WIDTH-1:0] count;

	logic dma_request;
	logic dma_rw;
	logic [ADDR_WIDTH-1:0] dma_address;
	logic [DATA_WIDTH-1:0] dma_wdata;
	logic [DATA_WIDTH-1:0] dma_rdata;
	logic dma_ready;

	logic ram_request;
	logic ram_rw;
	logic [RAM_INDEX_WIDTH-1:0] ram_index;
	logic [DATA_WIDTH-1:0] ram_wdata;
	logic [DATA_WIDTH-1:0] ram_rdata;
	logic ram_ready;

	dma_regs u_regs (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_reg_request(i_reg_request),
		.i_reg_rw(i_reg_rw),
		.i_reg_address(i_reg_address),
		.i_reg_wdata(i_reg_wdata),
		.o_reg_rdata(o_reg_rdata),
		.o_reg_ready(o_reg_ready),
		.i_busy(o_busy),
		.o_start(start),
		.o_from(from),
		.o_to(to),
		.o_count(count)
	);

	dma_engine u_engine (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_start(start),
		.i_from(from),
		.i_to(to),
		.i_count(count),
		.o_busy(o_busy),
		.o_done(o_done),
		.o_bus_request(dma_request),
		.o_bus_rw(dma_rw),
		.o_bus_address(dma_address),
		.o_bus_wdata(dma_wdata),
		.i_bus_rdata(dma_rdata),
		.i_bus_ready(dma_ready)
	);

	bus_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_host_request(i_host_request),
		.i_host_rw(i_host_rw),
		.i_host_address(i_host_address),
		.i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata),
		.o_host_ready(o_host_ready),
		.i_dma_request(dma_request),
		.i_dma_rw(dma_rw),
		.i_dma_address(dma_address),
		.i_dma_wdata(dma_wdata),
		.o_dma_rdata(dma_rdata),
		.o_dma_ready(dma_ready),
		.o_ram_request(ram_request),
		.o_ram_rw(ram_rw),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.i_ram_ready(ram_ready)
	);

	word_ram u_ram (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(ram_request),
		.i_rw(ram_rw),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

endmodule

/* hw/word_ram.sv */
`timescale 1ns/1ps

module word_ram import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_request,
	input logic i_rw,
	input logic [RAM_INDEX_WIDTH-1:0] i_index,
	input logic [DATA_WIDTH-1:0] i_wdata,
	output logic [DATA_WIDTH-1:0] o_rdata,
	output logic o_ready
);

	logic [DATA_WIDTH-1:0] mem [RAM_WORDS];

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_ready <= 1'b0;
		else
			o_ready <= i_request; // One cycle per access
	end

	// Storage and read port
	always_ff @(posedge i_clock) begin
		if (i_request) begin
			if (i_rw)
				mem[i_index] <= i_wdata;
			else
				o_rdata <= mem[i_index];
		end
	end

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_host_request,
	input logic i_host_rw,
	input logic [ADDR_WIDTH-1:0] i_host_address,
	input logic [DATA_WIDTH-1:0] i_host_wdata,
	output logic [DATA_WIDTH-1:0] o_host_rdata,
	output logic o_host_ready,

	input logic i_dma_request,
	input logic i_dma_rw,
	input logic [ADDR_WIDTH-1:0] i_dma_address,
	input logic [DATA_WIDTH-1:0] i_dma_wdata,
	output logic [DATA_WIDTH-1:0] o_dma_rdata,
	output logic o_dma_ready,

	output logic o_ram_request,
	output logic o_ram_rw,
	output logic [RAM_INDEX_WIDTH-1:0] o_ram_index,
	output logic [DATA_WIDTH-1:0] o_ram_wdata,
	input logic [DATA_WIDTH-1:0] i_ram_rdata,
	input logic i_ram_ready
);

	bus_owner_t owner;
	logic host_owns;
	logic dma_owns;

	assign host_owns = (owner == own_host);
	assign dma_owns = (owner == own_dma);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			owner <= own_none;
		end else if (owner == own_none) begin
			if (i_host_request)
				owner <= own_host; // Host first
			else if (i_dma_request)
				owner <= own_dma;
		end else if (i_ram_ready) begin
			owner <= own_none;
		end
	end

	// Request is masked in the ready cycle so the RAM does not repeat it
	always_comb begin
		o_ram_request = ((host_owns && i_host_request) || (dma_owns && i_dma_request))
			&& !i_ram_ready;
		o_ram_rw = dma_owns ? i_dma_rw : i_host_rw;
		// Word index drops the two byte-offset bits
		o_ram_index = dma_owns ? i_dma_address[RAM_INDEX_WIDTH+1:2]
			: i_host_address[RAM_INDEX_WIDTH+1:2];
		o_ram_wdata = dma_owns ? i_dma_wdata : i_host_wdata;
	end

	assign o_host_ready = host_owns && i_ram_ready;
	assign o_dma_ready = dma_owns && i_ram_ready;
	assign o_host_rdata = host_owns ? i_ram_rdata : '0;
	assign o_dma_rdata = dma_owns ? i_ram_rdata : '0;

endmodule

/* hw/dma_engine.sv */
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_start,
	input logic [ADDR_WIDTH-1:0] i_from,
	input logic [ADDR_WIDTH-1:0] i_to,
	input logic [DATA_WIDTH-1:0] i_count,
	output logic o_busy,
	output logic o_done,

	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [ADDR_WIDTH-1:0] o_bus_address,
	output logic [DATA_WIDTH-1:0] o_bus_wdata,
	input logic [DATA_WIDTH-1:0] i_bus_rdata,
	input logic i_bus_ready
);

	engine_state_t state;
	logic [ADDR_WIDTH-1:0] src;
	logic [ADDR_WIDTH-1:0] dst;
	logic [DATA_WIDTH-1:0] remaining;
	logic start_go;
	logic issue;
	logic complete;

	assign start_go = (state == st_idle) && i_start; // Ignored while busy
	assign issue = (state != st_idle) && !o_bus_request;
	assign complete = o_bus_request && i_bus_ready;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= st_idle;
			o_bus_request <= 1'b0;
			o_busy <= 1'b0;
			o_done <= 1'b0;
			remaining <= '0;
		end else begin
			o_done <= 1'b0;
			case (state)
				st_idle: begin
					if (i_start) begin
						if (i_count == '0) begin
							o_done <= 1'b1; // Nothing to copy
						end else begin
							state <= st_read;
							o_bus_request <= 1'b1;
							o_busy <= 1'b1;
							remaining <= i_count;
						end
					end
				end
				st_read: begin
					if (issue) begin
						o_bus_request <= 1'b1;
					end else if (complete) begin
						o_bus_request <= 1'b0;
						state <= st_write;
					end
				end
				st_write: begin
					if (issue) begin
						o_bus_request <= 1'b1;
					end else if (complete) begin
						o_bus_request <= 1'b0;
						remaining <= remaining - 1'b1;
						if (remaining == DATA_WIDTH'(1)) begin
							state <= st_idle;
							o_busy <= 1'b0;
							o_done <= 1'b1;
						end else begin
							state <= st_read;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Addresses and write data follow the control above
	always_ff @(posedge i_clock) begin
		if (start_go) begin
			src <= i_from;
			dst <= i_to;
			o_bus_rw <= 1'b0;
			o_bus_address <= i_from;
		end else if (issue) begin
			o_bus_rw <= (state == st_write);
			o_bus_address <= (state == st_write) ? dst : src;
		end
		if (complete && state == st_read)
			o_bus_wdata <= i_bus_rdata; // Held until the write lands
		if (complete && state == st_write) begin
			src <= src + ADDR_WIDTH'(WORD_BYTES);
			dst <= dst + ADDR_WIDTH'(WORD_BYTES);
		end
	end

endmodule

/* hw/dma_regs.sv */
`timescale 1ns/1ps

module dma_regs import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_reg_request,
	input logic i_reg_rw,
	input reg_addr_t i_reg_address,
	input logic [DATA_WIDTH-1:0] i_reg_wdata,
	output logic [DATA_WIDTH-1:0] o_reg_rdata,
	output logic o_reg_ready,

	input logic i_busy,
	output logic o_start,
	output logic [ADDR_WIDTH-1:0] o_from,
	output logic [ADDR_WIDTH-1:0] o_to,
	output logic [DATA_WIDTH-1:0] o_count
);

	logic [DATA_WIDTH-1:0] read_value;

	// Status reads all ones while a copy runs
	always_comb begin
		case (i_reg_address)
			reg_from: read_value = DATA_WIDTH'(o_from);
			reg_to: read_value = DATA_WIDTH'(o_to);
			reg_count: read_value = o_count;
			reg_ctrl: read_value = i_busy ? '1 : '0;
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_from <= '0;
			o_to <= '0;
			o_count <= '0;
			o_start <= 1'b0;
			o_reg_ready <= 1'b0;
			o_reg_rdata <= '0;
		end else begin
			o_start <= 1'b0;
			o_reg_ready <= i_reg_request; // Every access acked next cycle
			if (i_reg_request) begin
				if (i_reg_rw) begin
					case (i_reg_address)
						reg_from: o_from <= ADDR_WIDTH'(i_reg_wdata);
						reg_to: o_to <= ADDR_WIDTH'(i_reg_wdata);
						reg_count: o_count <= i_reg_wdata;
						reg_ctrl: o_start <= 1'b1;
						default: o_start <= 1'b0;
					endcase
				end else begin
					o_reg_rdata <= read_value;
				end
			end
		end
	end

endmodule

/* hw/dma_pkg.sv */
package dma_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_WIDTH = 8;
	localparam int WORD_BYTES = 4;

	// Register map of the control port
	typedef enum logic [1:0] {
		reg_from = 2'd0,
		reg_to = 2'd1,
		reg_count = 2'd2,
		reg_ctrl = 2'd3 // Write starts, read gives busy
	} reg_addr_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_read = 2'd1,
		st_write = 2'd2
	} engine_state_t;

	typedef enum logic [1:0] {
		own_none = 2'd0,
		own_host = 2'd1,
		own_dma = 2'd2
	} bus_owner_t;

endpackage
